// ==== dv/tb_cache_tasks.svh ====
// Directed cache tests with the driver, model and check helpers they share
// Included inside the testbench top module

function automatic cache_pkg::word_t mem_word(logic [31:0] addr);
  if (mem.exists(addr))
    return mem[addr];
  return addr ^ {addr[15:0], addr[31:16]} ^ 32'h3c5a_96e1;  // Untouched memory pattern
endfunction

function automatic void model_reset();
  for (int s = 0; s < `CACHE_SETS; s++) begin
    for (int w = 0; w < `CACHE_WAYS; w++) begin
      m_valid[s][w] = 1'b0;
      m_dirty[s][w] = 1'b0;
      m_tag[s][w]   = '0;
      m_age[s][w]   = w;
    end
  end
endfunction

function automatic void check_val(string name, logic [31:0] exp, logic [31:0] act);
  checks++;
  if (exp !== act) begin
    errors++;
    $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
  end
endfunction

// Lowest invalid way, else the oldest one
function automatic int pick_victim(int set);
  int v;
  v = 0;
  for (int w = `CACHE_WAYS - 1; w >= 0; w--)
    if (m_age[set][w] == 0) v = w;
  for (int w = `CACHE_WAYS - 1; w >= 0; w--)
    if (!m_valid[set][w]) v = w;
  return v;
endfunction

function automatic void touch_age(int set, int way);
  int old;
  old = m_age[set][way];
  for (int w = 0; w < `CACHE_WAYS; w++)
    if (m_age[set][w] > old) m_age[set][w]--;
  m_age[set][way] = `CACHE_WAYS - 1;
endfunction

////////////////////////////////////////
// Bus helpers, called on a falling edge
////////////////////////////////////////
task automatic send_request(cache_pkg::req_op_t op, logic [31:0] addr, cache_pkg::word_t data);
  req_valid   = 1'b1;
  req_op      = op;
  req_address = addr;
  req_data    = data;
  while (!req_ready) @(negedge cclk);
  @(negedge cclk);   // Accept edge has passed
  req_valid = 1'b0;
endtask

task automatic wait_ack(string name, output int waited);
  waited = 0;
  do begin
    @(negedge cclk);
    waited++;
  end while (!ack_valid && waited < 20);
  if (!ack_valid) begin
    errors++;
    $display("%s: the cache gave no ack within 20 cycles", name);
  end
endtask

// Fill words come from the memory model, with random gaps
task automatic serve_fill(logic [31:0] line_addr, int set, int way);
  for (int b = 0; b < `CACHE_WORDS; b++) begin
    m_line[set][way][b] = mem_word(line_addr + 4 * b);
    repeat ($urandom_range(0, 2)) @(negedge cclk);
    send_request(cache_pkg::op_fill, 32'h0, m_line[set][way][b]);
  end
endtask

// One read or write, every ack checked against the model
task automatic access(string name, cache_pkg::req_op_t op, logic [31:0] addr,
                      cache_pkg::word_t data, output logic dut_hit);
  int set;
  int off;
  int way;
  int waited;
  logic model_hit;
  cache_pkg::tag_t tag;
  logic [31:0] wb_addr;
  set = addr[7:4];
  off = addr[3:2];
  tag = addr[31:8];
  way = -1;
  for (int w = 0; w < `CACHE_WAYS; w++)
    if (m_valid[set][w] && m_tag[set][w] == tag) way = w;
  model_hit = (way >= 0);
  send_request(op, addr, data);
  check_val({name, " req_ready in lookup"}, 0, req_ready);
  if (!model_hit) begin
    way = pick_victim(set);
    if (m_valid[set][way] && m_dirty[set][way]) begin
      wb_addr = {m_tag[set][way], cache_pkg::index_t'(set), 4'h0};
      for (int b = 0; b < `CACHE_WORDS; b++) begin
        wait_ack(name, waited);
        check_val({name, " writeback delay"}, 1, waited);
        check_val({name, " writeback type"}, cache_pkg::ack_writeback, ack_type);
        check_val({name, " writeback address"}, wb_addr, ack_address);
        check_val({name, " writeback data"}, m_line[set][way][b], ack_data);
        check_val({name, " writeback ack_last"}, (b == `CACHE_WORDS - 1), ack_last);
        mem[wb_addr + 4 * b] = m_line[set][way][b];
      end
    end
    wait_ack(name, waited);
    check_val({name, " fetch delay"}, 1, waited);
    check_val({name, " fetch type"}, cache_pkg::ack_fetch, ack_type);
    check_val({name, " fetch address"}, {addr[31:4], 4'h0}, ack_address);
    check_val({name, " fetch ack_last"}, 0, ack_last);
    serve_fill({addr[31:4], 4'h0}, set, way);
    m_valid[set][way] = 1'b1;
    m_tag[set][way]   = tag;
    m_dirty[set][way] = 1'b0;
  end
  if (op == cache_pkg::op_write) begin
    m_line[set][way][off] = data;
    m_dirty[set][way]     = 1'b1;
  end
  touch_age(set, way);
  wait_ack(name, waited);
  check_val({name, " response delay"}, 1, waited);
  check_val({name, " response type"},
            (op == cache_pkg::op_write) ? cache_pkg::ack_write : cache_pkg::ack_read, ack_type);
  check_val({name, " ack_hit"}, model_hit, ack_hit);
  check_val({name, " response ack_last"}, 0, ack_last);
  check_val({name, " req_ready with response"}, 1, req_ready);
  if (op == cache_pkg::op_read)
    check_val({name, " read data"}, m_line[set][way][off], ack_data);
  dut_hit = ack_hit;
endtask

////////////////////////////////////////
// Directed tests
////////////////////////////////////////
task automatic test_reset_state();
  check_val("reset req_ready", 1, req_ready);
  check_val("reset ack_valid", 0, ack_valid);
  check_val("reset ack_hit", 0, ack_hit);
  check_val("reset ack_last", 0, ack_last);
endtask

task automatic test_cold_read_miss();
  logic hit;
  access("cold read miss", cache_pkg::op_read, 32'h00ab_c034, '0, hit);
  check_val("cold read miss is a miss", 0, hit);
endtask

task automatic test_read_hit();
  logic hit;
  access("read hit", cache_pkg::op_read, 32'h00ab_c034, '0, hit);
  check_val("read hit is a hit", 1, hit);
endtask

task automatic test_write_hit_merge();
  logic hit;
  access("write hit", cache_pkg::op_write, 32'h00ab_c038, 32'hdead_beef, hit);
  access("read after write", cache_pkg::op_read, 32'h00ab_c038, '0, hit);
  access("read neighbour word", cache_pkg::op_read, 32'h00ab_c03c, '0, hit);
endtask

// Five lines in set 5, the written ones are evicted in turn
task automatic test_dirty_eviction();
  logic hit;
  int   wb_before;
  wb_before = wb_seen;
  access("eviction fill 0", cache_pkg::op_write, 32'h0001_0050, 32'h1111_0000, hit);
  access("eviction fill 1", cache_pkg::op_write, 32'h0001_0158, 32'h2222_0002, hit);
  access("eviction fill 2", cache_pkg::op_read, 32'h0001_0254, '0, hit);
  access("eviction fill 3", cache_pkg::op_read, 32'h0001_035c, '0, hit);
  access("eviction fill 4", cache_pkg::op_read, 32'h0001_0450, '0, hit);
  access("eviction refetch 0", cache_pkg::op_read, 32'h0001_0050, '0, hit);
  check_val("dirty eviction writebacks", 2, wb_seen - wb_before);
endtask

task automatic test_random_traffic();
  logic               hit;
  int                 line;
  logic [31:0]        addr;
  cache_pkg::req_op_t op;
  for (int i = 0; i < 100; i++) begin
    line = $urandom_range(0, 7);
    // Lines 0 to 4 crowd set 3 so that dirty lines keep getting evicted
    addr = {cache_pkg::tag_t'(24'h000200 + line), (line < 5) ? 4'h3 : 4'h5,
            2'($urandom_range(0, 3)), 2'b00};
    op   = ($urandom_range(0, 1) == 1) ? cache_pkg::op_write : cache_pkg::op_read;
    access("random traffic", op, addr, $urandom, hit);
  end
endtask

// ==== dv/tb_cache_top.sv ====
// Testbench for the 4-way write-back data cache
// Holds the clock, reset, memory and cache models, timeout and summary; tests are included
`timescale 1ns/1ps
`default_nettype none

`include "cache_consts.svh"

module tb_cache_top;

  // About 120 accesses at up to 16 cycles each, plus margin
  localparam int TIMEOUT_CYCLES = 2500;

  logic                 cclk;
  logic                 cresetn;
  logic                 req_valid;
  cache_pkg::req_op_t   req_op;
  logic [31:0]          req_address;
  cache_pkg::word_t     req_data;
  logic                 req_ready;
  logic                 ack_valid;
  logic                 ack_hit;
  cache_pkg::ack_type_t ack_type;
  cache_pkg::word_t     ack_data;
  logic [31:0]          ack_address;
  logic                 ack_last;

  int checks;
  int errors;
  int cycle_count;
  int wb_seen;      // Dirty lines written back so far

  ////////////////////////////////////////
  // Cache and memory models
  ////////////////////////////////////////
  logic             m_valid [`CACHE_SETS][`CACHE_WAYS];
  cache_pkg::tag_t  m_tag   [`CACHE_SETS][`CACHE_WAYS];
  logic             m_dirty [`CACHE_SETS][`CACHE_WAYS];
  int               m_age   [`CACHE_SETS][`CACHE_WAYS];
  cache_pkg::word_t m_line  [`CACHE_SETS][`CACHE_WAYS][`CACHE_WORDS];
  cache_pkg::word_t mem [logic [31:0]];  // Written-back words only

  cache_top UUT (
    .cclk, .cresetn, .req_valid, .req_op, .req_address, .req_data,
    .req_ready, .ack_valid, .ack_hit, .ack_type, .ack_data, .ack_address, .ack_last
  );

  initial begin
    cclk = 1'b0;
    forever #5 cclk = ~cclk;
  end

  always @(posedge cclk) begin
    cycle_count++;
    if (cycle_count > TIMEOUT_CYCLES) begin
      $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("** FAIL **");
      $finish;
    end
  end

  // Completed write-back bursts as seen on the ack port
  always @(negedge cclk) begin
    if (cresetn && ack_valid && ack_type == cache_pkg::ack_writeback && ack_last)
      wb_seen++;
  end

  `include "tb_cache_tasks.svh"

  initial begin
    void'($urandom(97));
    cresetn     = 1'b0;
    req_valid   = 1'b0;
    req_op      = cache_pkg::op_read;
    req_address = '0;
    req_data    = '0;
    checks      = 0;
    errors      = 0;
    cycle_count = 0;
    wb_seen     = 0;
    model_reset();
    repeat (5) @(posedge cclk);
    @(negedge cclk);
    cresetn = 1'b1;

    test_reset_state();
    test_cold_read_miss();
    test_read_hit();
    test_write_hit_merge();
    test_dirty_eviction();
    test_random_traffic();

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0)
      $display("** PASS **");
    else
      $display("** FAIL **");
    $finish;
  end

endmodule

`default_nettype wire

// ==== files.f ====
+incdir+logic
+incdir+dv
logic/cache_pkg.sv
logic/way_ram.sv
logic/beat_counter.sv
logic/tag_lookup.sv
logic/line_datapath.sv
logic/cache_ctrl_fsm.sv
logic/cache_top.sv
dv/tb_cache_top.sv

// ==== logic/beat_counter.sv ====
// Word counter for write-back and fill bursts
// Wraps after the last word of a line
`timescale 1ns/1ps
`default_nettype none

`include "cache_consts.svh"

module beat_counter (
  input  wire                 cclk,
  input  wire                 cresetn,
  input  wire                 count_en,
  input  wire                 count_clr,
  output cache_pkg::offset_t  beat,
  output logic                beat_last
);

  assign beat_last = (beat == cache_pkg::offset_t'(`CACHE_WORDS - 1));

  always_ff @(posedge cclk or negedge cresetn) begin
    if (!cresetn)
      beat <= '0;
    else if (count_clr || (count_en && beat_last))
      beat <= '0;
    else if (count_en)
      beat <= beat + 1'b1;
  end

endmodule

`default_nettype wire

// ==== logic/cache_consts.svh ====
// Geometry and width constants of the 4-way data cache
// Included by the package and by every module that sizes arrays or slices
`ifndef CACHE_CONSTS_SVH
`define CACHE_CONSTS_SVH

`define CACHE_WAYS      4
`define CACHE_SETS      16
`define CACHE_INDEX_W   4   // log2 of CACHE_SETS
`define CACHE_WORDS     4   // Words per line
`define CACHE_OFFSET_W  2   // Word within a line
`define CACHE_WORD_W    32

// 32-bit address minus index, word offset and 2 byte bits
`define CACHE_TAG_W     24

`define CACHE_AGE_W     2   // LRU age, 0 is the oldest way

`endif

// ==== logic/cache_ctrl_fsm.sv ====
// Request access FSM of the cache
// Steps through lookup, write-back, fetch, fill and the response ack
`timescale 1ns/1ps
`default_nettype none

`include "cache_consts.svh"

module cache_ctrl_fsm (
  input  wire                       cclk,
  input  wire                       cresetn,
  input  wire                       req_valid,
  input  wire cache_pkg::req_op_t   req_op,
  input  wire                       hit,
  input  wire                       victim_dirty,
  input  wire                       beat_last,
  output logic                      req_ready,
  output logic                      lookup,
  output logic                      capture,
  output logic                      fill_shift,
  output logic                      fill_done,
  output logic                      count_en,
  output logic                      count_clr,
  output logic                      tag_we,
  output logic                      data_we,
  output logic                      ack_valid,
  output logic                      ack_hit,
  output cache_pkg::ack_type_t      ack_type,
  output logic                      ack_last,
  output logic                      ack_sel_victim
);

  typedef enum logic [2:0] {
    st_idle, st_lookup, st_respond, st_flush, st_fetch, st_fill, st_update, st_resp_miss
  } state_t;

  state_t state;
  state_t state_nxt;
  logic   write_q;   // Operation of the request in flight

  assign req_ready  = state inside {st_idle, st_respond, st_resp_miss, st_fill};
  assign capture    = req_valid && (req_op != cache_pkg::op_fill) &&
                      (state inside {st_idle, st_respond, st_resp_miss});
  assign lookup     = (state == st_lookup);
  assign fill_shift = (state == st_fill) && req_valid;
  assign fill_done  = (state == st_update);
  assign count_clr  = lookup;
  assign count_en   = (state == st_flush) || fill_shift;
  assign tag_we     = (lookup && hit) || fill_done;
  assign data_we    = (lookup && hit && write_q) || fill_done;  // Write hit merge or line fill
  assign ack_last   = (state == st_flush) && beat_last;

  always_comb begin
    state_nxt = state;
    case (state)
      st_idle, st_respond, st_resp_miss: state_nxt = capture ? st_lookup : st_idle;
      st_lookup: begin
        if (hit)
          state_nxt = st_respond;
        else if (victim_dirty)
          state_nxt = st_flush;
        else
          state_nxt = st_fetch;
      end
      st_flush:  if (beat_last) state_nxt = st_fetch;
      st_fetch:  state_nxt = st_fill;
      st_fill:   if (fill_shift && beat_last) state_nxt = st_update;
      st_update: state_nxt = st_resp_miss;
      default:   state_nxt = st_idle;
    endcase
  end

  ////////////////////////////////////////
  // State and registered ack controls
  ////////////////////////////////////////
  always_ff @(posedge cclk or negedge cresetn) begin
    if (!cresetn) begin
      state          <= st_idle;
      write_q        <= 1'b0;
      ack_valid      <= 1'b0;
      ack_hit        <= 1'b0;
      ack_type       <= cache_pkg::ack_fetch;
      ack_sel_victim <= 1'b0;
    end else begin
      state          <= state_nxt;
      ack_valid      <= state_nxt inside {st_respond, st_resp_miss, st_flush, st_fetch};
      ack_hit        <= (state_nxt == st_respond);
      ack_sel_victim <= (state_nxt == st_flush);
      if (capture)
        write_q <= (req_op == cache_pkg::op_write);
      case (state_nxt)
        st_flush: ack_type <= cache_pkg::ack_writeback;
        st_respond, st_resp_miss:
          ack_type <= write_q ? cache_pkg::ack_write : cache_pkg::ack_read;
        default:  ack_type <= cache_pkg::ack_fetch;
      endcase
    end
  end

  // Memory only sends fill words while a line is being fetched
  assert property (@(posedge cclk) disable iff (!cresetn)
    (state == st_fill && req_valid) |-> (req_op == cache_pkg::op_fill));

  // Last flag closes a full write-back burst of one line
  assert property (@(posedge cclk) disable iff (!cresetn)
    ack_last |-> $past(state == st_flush, `CACHE_WORDS - 1));

endmodule

`default_nettype wire

// ==== logic/cache_pkg.sv ====
// Types shared by the cache blocks
// Referenced with scoped names from the RTL and the testbench
`default_nettype none

`include "cache_consts.svh"

package cache_pkg;

  // Requester operation, 2'b00 is not used
  typedef enum logic [1:0] {
    op_read  = 2'b01,
    op_write = 2'b10,
    op_fill  = 2'b11
  } req_op_t;

  // Ack kinds as seen by the requester and memory
  typedef enum logic [1:0] {
    ack_fetch     = 2'b00,
    ack_read      = 2'b01,
    ack_write     = 2'b10,
    ack_writeback = 2'b11
  } ack_type_t;

  typedef logic [`CACHE_WORD_W-1:0]              word_t;
  typedef logic [`CACHE_WORDS*`CACHE_WORD_W-1:0] line_t;
  typedef logic [`CACHE_TAG_W-1:0]               tag_t;
  typedef logic [`CACHE_INDEX_W-1:0]             index_t;
  typedef logic [`CACHE_OFFSET_W-1:0]            offset_t;
  typedef logic [`CACHE_WAYS-1:0]                way_mask_t;
  typedef logic [`CACHE_AGE_W-1:0]               age_t;

  // Entry held in the tag ways
  typedef struct packed {
    tag_t tag;
    logic dirty;
  } tag_entry_t;

endpackage

`default_nettype wire

// ==== logic/cache_top.sv ====
// Top level of the blocking write-back 4-way data cache
// Connects the FSM, beat counter, tag lookup, line datapath and way memories
`timescale 1ns/1ps
`default_nettype none

`include "cache_consts.svh"

module cache_top (
  input  wire                         cclk,
  input  wire                         cresetn,
  input  wire                         req_valid,
  input  wire cache_pkg::req_op_t     req_op,
  input  wire [31:0]                  req_address,
  input  wire cache_pkg::word_t       req_data,
  output wire                         req_ready,
  output wire                         ack_valid,
  output wire                         ack_hit,
  output wire cache_pkg::ack_type_t   ack_type,
  output wire cache_pkg::word_t       ack_data,
  output wire [31:0]                  ack_address,
  output wire                         ack_last
);

  logic                  lookup;
  logic                  capture;
  logic                  fill_shift;
  logic                  fill_done;
  logic                  count_en;
  logic                  count_clr;
  logic                  tag_we;
  logic                  data_we;
  logic                  ack_sel_victim;
  logic                  hit;
  logic                  victim_dirty;
  logic                  beat_last;
  cache_pkg::offset_t    beat;
  cache_pkg::way_mask_t  hit_way;
  cache_pkg::way_mask_t  victim_way;
  cache_pkg::way_mask_t  tag_wmask;
  cache_pkg::tag_t       victim_tag;
  cache_pkg::tag_t       req_tag;
  cache_pkg::index_t     req_index;
  logic                  req_is_write;
  cache_pkg::tag_entry_t tag_wdata;
  cache_pkg::line_t      line_wdata;
  cache_pkg::tag_entry_t way_tag [`CACHE_WAYS];
  cache_pkg::line_t      way_line [`CACHE_WAYS];

  cache_ctrl_fsm u_ctrl (
    .cclk, .cresetn, .req_valid, .req_op, .hit, .victim_dirty, .beat_last,
    .req_ready, .lookup, .capture, .fill_shift, .fill_done, .count_en, .count_clr,
    .tag_we, .data_we, .ack_valid, .ack_hit, .ack_type, .ack_last, .ack_sel_victim
  );

  beat_counter u_beat (
    .cclk, .cresetn, .count_en, .count_clr, .beat, .beat_last
  );

  tag_lookup u_tags (
    .cclk, .cresetn, .lookup, .tag_we, .req_tag, .req_index, .req_is_write, .way_tag,
    .hit, .hit_way, .victim_way, .victim_dirty, .victim_tag, .tag_wdata, .tag_wmask
  );

  line_datapath u_data (
    .cclk, .cresetn, .capture, .fill_shift, .fill_done, .req_address, .req_data, .req_op,
    .fill_data (req_data),
    .hit_way, .victim_way, .victim_tag, .beat, .ack_sel_victim, .way_line,
    .req_tag, .req_index, .req_is_write, .line_wdata, .ack_data, .ack_address
  );

  ////////////////////////////////////////
  // Way memories, one tag and one line array per way
  ////////////////////////////////////////
  for (genvar w = 0; w < `CACHE_WAYS; w++) begin : g_way
    way_ram #(.entry_t(cache_pkg::tag_entry_t)) u_tag_ram (
      .cclk, .we (tag_we & tag_wmask[w]), .waddr (req_index), .wdata (tag_wdata),
      .raddr (req_index), .rdata (way_tag[w])
    );
    way_ram #(.entry_t(cache_pkg::line_t)) u_line_ram (
      .cclk, .we (data_we & tag_wmask[w]), .waddr (req_index), .wdata (line_wdata),
      .raddr (req_index), .rdata (way_line[w])
    );
  end

endmodule

`default_nettype wire

// ==== logic/line_datapath.sv ====
// Request register, fill line buffer, write merge and word select
// Also forms the line address for fetch and write-back acks
`timescale 1ns/1ps
`default_nettype none

`include "cache_consts.svh"

module line_datapath (
  input  wire                         cclk,
  input  wire                         cresetn,
  input  wire                         capture,
  input  wire                         fill_shift,
  input  wire                         fill_done,
  input  wire [31:0]                  req_address,
  input  wire cache_pkg::word_t       req_data,
  input  wire cache_pkg::req_op_t     req_op,
  input  wire cache_pkg::word_t       fill_data,
  input  wire cache_pkg::way_mask_t   hit_way,
  input  wire cache_pkg::way_mask_t   victim_way,
  input  wire cache_pkg::tag_t        victim_tag,
  input  wire cache_pkg::offset_t     beat,
  input  wire                         ack_sel_victim,
  input  wire cache_pkg::line_t       way_line [`CACHE_WAYS],
  output cache_pkg::tag_t             req_tag,
  output cache_pkg::index_t           req_index,
  output logic                        req_is_write,
  output cache_pkg::line_t            line_wdata,
  output cache_pkg::word_t            ack_data,
  output logic [31:0]                 ack_address
);

  localparam int BYTE_W = 2;
  localparam int W      = `CACHE_WORD_W;

  cache_pkg::offset_t req_offset;
  cache_pkg::word_t   req_word;
  cache_pkg::line_t   fill_buf;
  cache_pkg::line_t   hit_line;
  cache_pkg::line_t   victim_line;

  always_ff @(posedge cclk or negedge cresetn) begin
    if (!cresetn) begin
      req_tag      <= '0;
      req_index    <= '0;
      req_offset   <= '0;
      req_is_write <= 1'b0;
    end else if (capture) begin
      req_tag      <= req_address[31 -: `CACHE_TAG_W];
      req_index    <= req_address[BYTE_W + `CACHE_OFFSET_W +: `CACHE_INDEX_W];
      req_offset   <= req_address[BYTE_W +: `CACHE_OFFSET_W];
      req_is_write <= (req_op == cache_pkg::op_write);
    end
  end

  always_ff @(posedge cclk) begin
    if (capture)
      req_word <= req_data;
    if (fill_shift)
      fill_buf <= {fill_data, fill_buf[`CACHE_WORDS*W-1:W]};  // First word ends up lowest
  end

  always_comb begin
    hit_line    = '0;
    victim_line = '0;
    for (int w = 0; w < `CACHE_WAYS; w++) begin
      if (hit_way[w])    hit_line    = hit_line | way_line[w];
      if (victim_way[w]) victim_line = victim_line | way_line[w];
    end
    line_wdata = fill_done ? fill_buf : hit_line;
    if (req_is_write)
      line_wdata[req_offset*W +: W] = req_word;
  end

  assign ack_data    = ack_sel_victim ? victim_line[beat*W +: W] : hit_line[req_offset*W +: W];
  assign ack_address = {ack_sel_victim ? victim_tag : req_tag, req_index,
                        {(`CACHE_OFFSET_W + BYTE_W){1'b0}}};

endmodule

`default_nettype wire

// ==== logic/tag_lookup.sv ====
// Tag compare, valid bits, LRU ages and victim choice
// Ages and valid bits live here, tags and dirty bits in the tag ways
`timescale 1ns/1ps
`default_nettype none

`include "cache_consts.svh"

module tag_lookup (
  input  wire                         cclk,
  input  wire                         cresetn,
  input  wire                         lookup,
  input  wire                         tag_we,
  input  wire cache_pkg::tag_t        req_tag,
  input  wire cache_pkg::index_t      req_index,
  input  wire                         req_is_write,
  input  wire cache_pkg::tag_entry_t  way_tag [`CACHE_WAYS],
  output logic                        hit,
  output cache_pkg::way_mask_t        hit_way,
  output cache_pkg::way_mask_t        victim_way,
  output logic                        victim_dirty,
  output cache_pkg::tag_t             victim_tag,
  output cache_pkg::tag_entry_t       tag_wdata,
  output cache_pkg::way_mask_t        tag_wmask
);

  cache_pkg::way_mask_t valid_q [`CACHE_SETS];
  cache_pkg::age_t      age_q [`CACHE_SETS][`CACHE_WAYS];
  cache_pkg::way_mask_t victim_q;     // Held from lookup until the line is replaced
  cache_pkg::way_mask_t victim_comb;
  cache_pkg::way_mask_t way_dirty;
  cache_pkg::age_t      acc_age;      // Old age of the way being written

  always_comb begin
    victim_comb = '0;
    victim_tag  = '0;
    acc_age     = '0;
    for (int w = 0; w < `CACHE_WAYS; w++) begin
      hit_way[w]   = valid_q[req_index][w] && (way_tag[w].tag == req_tag);
      way_dirty[w] = valid_q[req_index][w] && way_tag[w].dirty;
    end
    // Oldest way first, any invalid way takes precedence
    for (int w = `CACHE_WAYS - 1; w >= 0; w--) begin
      if (age_q[req_index][w] == '0) begin
        victim_comb    = '0;
        victim_comb[w] = 1'b1;
      end
    end
    for (int w = `CACHE_WAYS - 1; w >= 0; w--) begin
      if (!valid_q[req_index][w]) begin
        victim_comb    = '0;
        victim_comb[w] = 1'b1;
      end
    end
    victim_way = lookup ? victim_comb : victim_q;
    hit        = |hit_way;
    tag_wmask  = hit ? hit_way : victim_way;
    for (int w = 0; w < `CACHE_WAYS; w++) begin
      if (victim_way[w]) victim_tag = way_tag[w].tag;
      if (tag_wmask[w])  acc_age    = age_q[req_index][w];
    end
    victim_dirty    = |(victim_way & way_dirty);
    tag_wdata.tag   = req_tag;
    tag_wdata.dirty = req_is_write || (hit && |(hit_way & way_dirty));  // Read fill clears
  end

  ////////////////////////////////////////
  // Valid and LRU age update
  ////////////////////////////////////////
  always_ff @(posedge cclk or negedge cresetn) begin
    if (!cresetn) begin
      victim_q <= '0;
      for (int s = 0; s < `CACHE_SETS; s++) begin
        valid_q[s] <= '0;
        for (int w = 0; w < `CACHE_WAYS; w++)
          age_q[s][w] <= cache_pkg::age_t'(w);
      end
    end else begin
      if (lookup)
        victim_q <= victim_comb;
      if (tag_we) begin
        valid_q[req_index] <= valid_q[req_index] | tag_wmask;
        for (int w = 0; w < `CACHE_WAYS; w++) begin
          if (tag_wmask[w])
            age_q[req_index][w] <= '1;  // Most recently used
          else if (age_q[req_index][w] > acc_age)
            age_q[req_index][w] <= age_q[req_index][w] - 1'b1;
        end
      end
    end
  end

  // Tag ways never hold the same valid tag twice in a set
  assert property (@(posedge cclk) disable iff (!cresetn) $onehot0(hit_way));

endmodule

`default_nettype wire

// ==== logic/way_ram.sv ====
// One way of cache storage, one entry per set
// Read is combinational, write lands on the clock edge
`timescale 1ns/1ps
`default_nettype none

`include "cache_consts.svh"

module way_ram #(
  parameter type entry_t = logic [31:0]
) (
  input  wire                     cclk,
  input  wire                     we,
  input  wire cache_pkg::index_t  waddr,
  input  wire entry_t             wdata,
  input  wire cache_pkg::index_t  raddr,
  output entry_t                  rdata
);

  entry_t mem [`CACHE_SETS];

  always_ff @(posedge cclk) begin
    if (we)
      mem[waddr] <= wdata;
  end

  assign rdata = mem[raddr];

  assert property (@(posedge cclk) we |-> !$isunknown(waddr));

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the cache testbench with Verilator, runs it and scans the log for a failure
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f files.f --top-module tb_cache_top \
  -o tb_cache_top > build.log 2>&1 \
  && ./obj_dir/tb_cache_top > sim.log 2>&1 \
  || { echo "Build or simulation run did not complete, see build.log and sim.log"; exit 1; }

grep -q '\*\* FAIL \*\*' sim.log \
  && { echo "Simulation reported errors, see sim.log"; exit 1; } \
  || { echo "Simulation finished without errors"; exit 0; }
